/* testbench/dram_vectors.txt */
// kind[31:28]: 1 request (op bit 24, addr 18:0), 2 stall mode (bit 0),
// 4 wait for REF, 3 expected counts (RD 15:8, WR 7:0)
20000000
10009305
10009310
1100937F
1001A320
11002801
1007FFFF
11000CC0
10002802
20000001
11009305
1001A321
1007FF80
11000CC1
11003002
10002803
1001A322
1107FFF0
40000000
10000CC2
11000CC3
10002804
1101A32F
30000B09

/* build.f */
verilog/dram_geometry_pkg.sv
verilog/dram_cmd_pkg.sv
verilog/request_fifo.sv
verilog/bank_state.sv
verilog/refresh_timer.sv
verilog/cmd_scheduler.sv
verilog/dram_ctrl_top.sv
testbench/tb_dram_ctrl_sva.sv
testbench/tb_dram_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the DRAM command generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dram_ctrl -f build.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q -F -x '** PASS **' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* testbench/tb_dram_ctrl.sv */
`timescale 1ns/1ps

module tb_dram_ctrl
	import dram_geometry_pkg::*, dram_cmd_pkg::*;
;
	localparam int RP = 3;
	localparam int RCD = 3;
	localparam int CCD = 4;
	localparam int REFI = 200;
	localparam int RFC = 12;
	localparam int TIMEOUT = 2000; // cycles allowed for any single wait

	logic clk, rst_n, req_valid, req_ready, cmd_valid, cmd_ready;
	req_op_t req_op;
	addr_t req_addr;
	dram_cmd_t cmd;
	bg_t cmd_bg;
	bank_t cmd_bank;
	row_t cmd_row;
	col_t cmd_col;

	logic [31:0] vec [64];   // kind in [31:28]
	logic [19:0] exp_q [$];  // accepted requests as {op, addr} in arrival order
	logic model_open [NUM_BANKS];
	row_t model_row [NUM_BANKS];
	int last_pre [NUM_BANKS];
	int last_act [NUM_BANKS];
	int last_col, last_ref, cyc;
	int errors, timeouts, rd_count, wr_count, ref_count, exp_rd, exp_wr;
	logic stall_mode;

	dram_ctrl_top #(
		.FIFO_DEPTH(4), .T_RP(tcount_t'(RP)), .T_RCD(tcount_t'(RCD)), .T_CCD(tcount_t'(CCD)),
		.T_REFI(tcount_t'(REFI)), .T_RFC(tcount_t'(RFC))
	) dut0 (
		.clk, .rst_n, .req_valid, .req_op, .req_addr, .req_ready,
		.cmd_valid, .cmd_ready, .cmd, .cmd_bg, .cmd_bank, .cmd_row, .cmd_col
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic flag_error(input string msg);
		errors++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	task automatic finish_run;
		int sva_fails;
		sva_fails = dut0.sva0.fail_count;
		$display("errors %0d, assertion failures %0d, timeouts %0d, RD %0d/%0d, WR %0d/%0d, REF %0d",
			errors, sva_fails, timeouts, rd_count, exp_rd, wr_count, exp_wr, ref_count);
		if (errors == 0 && sva_fails == 0 && timeouts == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	task automatic give_up(input string what);
		timeouts++;
		$display("timed out waiting for %s", what);
	endtask

	// reference model fed with every command that transfers
	task automatic check_cmd;
		bank_idx_t b;
		logic have, any_open;
		logic [19:0] head;
		b = {cmd_bg, cmd_bank};
		have = (exp_q.size() > 0);
		head = have ? exp_q[0] : '0;
		any_open = 1'b0;
		for (int i = 0; i < NUM_BANKS; i++)
			any_open |= model_open[i];
		assert (cyc - last_ref > RFC) else flag_error("command inside T_RFC after REF");
		case (cmd)
			CMD_PRE: begin
				assert (have && b == head[10:7] && model_open[b] && model_row[b] != head[18:11])
					else flag_error("PRE without a row miss on the head bank");
				model_open[b] = 1'b0;
				last_pre[b] = cyc;
			end
			CMD_ACT: begin
				assert (have && b == head[10:7] && !model_open[b] && cmd_row == head[18:11])
					else flag_error("ACT with wrong bank or row, or bank open");
				assert (cyc - last_pre[b] >= RP) else flag_error("PRE to ACT below T_RP");
				model_open[b] = 1'b1;
				model_row[b] = cmd_row;
				last_act[b] = cyc;
			end
			CMD_RD, CMD_WR: begin
				assert (have && b == head[10:7] && cmd_col == head[6:0]
					&& (cmd == CMD_WR) == head[19])
					else flag_error("column command out of order or wrong fields");
				assert (model_open[b] && model_row[b] == head[18:11])
					else flag_error("column command on a row that is not open");
				assert (cyc - last_act[b] >= RCD) else flag_error("ACT to column below T_RCD");
				assert (cyc - last_col >= CCD) else flag_error("column gap below T_CCD");
				last_col = cyc;
				if (cmd == CMD_WR)
					wr_count++;
				else
					rd_count++;
				if (have)
					void'(exp_q.pop_front()); // request served
			end
			CMD_PREA: begin
				assert (any_open) else flag_error("PREA with no bank open");
				for (int i = 0; i < NUM_BANKS; i++) begin
					model_open[i] = 1'b0;
					last_pre[i] = cyc;
				end
			end
			CMD_REF: begin
				assert (!any_open) else flag_error("REF while a bank is open, PREA missing");
				ref_count++;
				last_ref = cyc;
			end
			default: flag_error("unknown command code");
		endcase
	endtask

	// cmd_ready and the monitor share one falling-edge process
	always @(negedge clk) begin
		cyc++;
		cmd_ready = stall_mode ? ($urandom % 4 != 0) : 1'b1;
		if (rst_n && cmd_valid && cmd_ready)
			check_cmd(); // transfers on the coming rising edge
	end

	task automatic send_request(input logic [31:0] v);
		int t;
		repeat ($urandom % 3) @(negedge clk); // random idle gap
		req_valid = 1'b1;
		req_op = req_op_t'(v[24]);
		req_addr = v[18:0];
		t = 0;
		while (!req_ready && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (!req_ready) begin
			give_up("req_ready");
		end else begin
			exp_q.push_back({v[24], v[18:0]});
			@(negedge clk);
		end
		req_valid = 1'b0;
	endtask

	task automatic wait_refresh;
		int t;
		t = 0;
		while (ref_count == 0 && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (ref_count == 0)
			give_up("a REF command");
	endtask

	task automatic wait_drain;
		int t;
		t = 0;
		while ((exp_q.size() != 0 || cmd_valid) && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (exp_q.size() != 0 || cmd_valid)
			give_up("the request queue to drain");
	endtask

	initial begin
		logic done;
		void'($urandom(32'h7436_6372));
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_op = REQ_RD;
		req_addr = '0;
		cmd_ready = 1'b1;
		stall_mode = 1'b0;
		cyc = 0;
		last_col = -1000;
		last_ref = -1000;
		for (int i = 0; i < NUM_BANKS; i++) begin
			model_open[i] = 1'b0;
			model_row[i] = '0;
			last_pre[i] = -1000;
			last_act[i] = -1000;
		end
		for (int i = 0; i < 64; i++)
			vec[i] = '0;
		$readmemh("testbench/dram_vectors.txt", vec);
		repeat (16) @(negedge clk);
		assert (req_ready && !cmd_valid)
			else flag_error("req_ready low or cmd_valid high at reset release");
		rst_n = 1'b1;
		done = 1'b0;
		for (int i = 0; i < 64 && !done && timeouts == 0; i++) begin
			case (vec[i][31:28])
				4'h1: send_request(vec[i]);
				4'h2: stall_mode = vec[i][0];
				4'h3: begin
					exp_rd = int'(vec[i][15:8]);
					exp_wr = int'(vec[i][7:0]);
					done = 1'b1;
				end
				4'h4: wait_refresh();
				default: begin
					$display("vectors file ended without expected counts");
					errors++;
					done = 1'b1;
				end
			endcase
		end
		if (timeouts == 0)
			wait_drain();
		if (timeouts == 0)
			wait_refresh();
		if (timeouts == 0) begin
			assert (rd_count == exp_rd && wr_count == exp_wr)
				else flag_error("final RD or WR count differs from vectors file");
		end
		finish_run();
	end

endmodule : tb_dram_ctrl

/* testbench/tb_dram_ctrl_sva.sv */
`timescale 1ns/1ps

module tb_dram_ctrl_sva
	import dram_geometry_pkg::*, dram_cmd_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input logic      req_valid,
	input req_op_t   req_op,
	input addr_t     req_addr,
	input logic      req_ready,
	input logic      cmd_valid,
	input logic      cmd_ready,
	input dram_cmd_t cmd,
	input bg_t       cmd_bg,
	input bank_t     cmd_bank,
	input row_t      cmd_row,
	input col_t      cmd_col
);

	int fail_count = 0; // failed assertions so far

	// nothing on the command stream while reset is held
	a_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !cmd_valid)
		else begin
			fail_count++;
			$error("cmd_valid high during reset");
		end

	// stalled command keeps its payload
	a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd) && $stable(cmd_bg)
			&& $stable(cmd_bank) && $stable(cmd_row) && $stable(cmd_col)))
		else begin
			fail_count++;
			$error("command changed while cmd_ready was low");
		end

	a_req_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({req_valid, req_ready})
		&& (!req_valid || !$isunknown({req_op, req_addr})))
		else begin
			fail_count++;
			$error("request handshake carries X");
		end

endmodule : tb_dram_ctrl_sva

bind dram_ctrl_top tb_dram_ctrl_sva sva0 (
	.clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
	.req_ready(req_ready), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
	.cmd_bg(cmd_bg), .cmd_bank(cmd_bank), .cmd_row(cmd_row), .cmd_col(cmd_col)
);

/* verilog/dram_ctrl_top.sv */
`timescale 1ns/1ps

module dram_ctrl_top
	import dram_geometry_pkg::*, dram_cmd_pkg::*;
#(
	parameter int      FIFO_DEPTH = 4,
	parameter tcount_t T_RP       = 8'd3,
	parameter tcount_t T_RCD      = 8'd3,
	parameter tcount_t T_CCD      = 8'd2,
	parameter tcount_t T_REFI     = 8'd200,
	parameter tcount_t T_RFC      = 8'd12
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      req_valid,
	input  req_op_t   req_op,
	input  addr_t     req_addr,
	output logic      req_ready,
	output logic      cmd_valid,
	input  logic      cmd_ready,
	output dram_cmd_t cmd,
	output bg_t       cmd_bg,
	output bank_t     cmd_bank,
	output row_t      cmd_row,
	output col_t      cmd_col
);

	// fifo to scheduler
	logic      head_valid;
	req_op_t   head_op;
	addr_t     head_addr;
	logic      head_pop;
	// scheduler and bank state
	bank_idx_t look_bank;
	logic      issue_fire;
	dram_cmd_t issue_cmd;
	bank_idx_t issue_bank;
	row_t      issue_row;
	logic      bank_open;
	row_t      open_row;
	logic      pre_ok, act_ok, col_ok;
	// refresh
	logic      refresh_due, refresh_busy, refresh_ack;

	request_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
		.clk, .rst_n, .req_valid, .req_op, .req_addr, .req_ready,
		.head_valid, .head_op, .head_addr, .head_pop
	);

	bank_state #(.T_RP(T_RP), .T_RCD(T_RCD), .T_CCD(T_CCD)) banks0 (
		.clk, .rst_n, .look_bank, .issue_fire, .issue_cmd, .issue_bank, .issue_row,
		.bank_open, .open_row, .pre_ok, .act_ok, .col_ok
	);

	refresh_timer #(.T_REFI(T_REFI), .T_RFC(T_RFC)) refresh0 (
		.clk, .rst_n, .refresh_ack, .refresh_due, .refresh_busy
	);

	cmd_scheduler sched0 (
		.clk, .rst_n, .head_valid, .head_op, .head_addr, .head_pop,
		.bank_open, .open_row, .pre_ok, .act_ok, .col_ok,
		.look_bank, .issue_fire, .issue_cmd, .issue_bank, .issue_row,
		.refresh_due, .refresh_busy, .refresh_ack,
		.cmd_valid, .cmd_ready, .cmd, .cmd_bg, .cmd_bank, .cmd_row, .cmd_col
	);

endmodule : dram_ctrl_top

/* verilog/cmd_scheduler.sv */
`timescale 1ns/1ps

module cmd_scheduler
	import dram_geometry_pkg::*, dram_cmd_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      head_valid,
	input  req_op_t   head_op,
	input  addr_t     head_addr,
	output logic      head_pop,
	input  logic      bank_open,
	input  row_t      open_row,
	input  logic      pre_ok,
	input  logic      act_ok,
	input  logic      col_ok,
	output bank_idx_t look_bank,
	output logic      issue_fire,
	output dram_cmd_t issue_cmd,
	output bank_idx_t issue_bank,
	output row_t      issue_row,
	input  logic      refresh_due,
	input  logic      refresh_busy,
	output logic      refresh_ack,
	output logic      cmd_valid,
	input  logic      cmd_ready,
	output dram_cmd_t cmd,
	output bg_t       cmd_bg,
	output bank_t     cmd_bank,
	output row_t      cmd_row,
	output col_t      cmd_col
);

	localparam int OPEN_CNT_W = $clog2(NUM_BANKS + 1);

	sched_state_t          state_q;
	sched_state_t          state_d;
	logic                  raise;     // load a new command onto the stream
	dram_cmd_t             raise_cmd;
	logic [OPEN_CNT_W-1:0] open_cnt;  // banks currently open
	col_t                  head_col;
	bank_t                 head_bank;
	bg_t                   head_bg;
	row_t                  head_row;

	// split the head address
	assign head_col  = head_addr[COL_LSB +: COL_WIDTH];
	assign head_bank = head_addr[BANK_LSB +: BANK_WIDTH];
	assign head_bg   = head_addr[BG_LSB +: BG_WIDTH];
	assign head_row  = head_addr[ROW_LSB +: ROW_WIDTH];

	assign look_bank = head_valid ? {head_bg, head_bank} : '0; // bank 0 when queue empty

	assign issue_fire  = cmd_valid && cmd_ready;
	assign issue_cmd   = cmd;
	assign issue_bank  = {cmd_bg, cmd_bank};
	assign issue_row   = cmd_row;
	assign refresh_ack = issue_fire && (cmd == CMD_REF);
	assign head_pop    = issue_fire && (cmd == CMD_RD || cmd == CMD_WR); // request done

	always_comb begin
		state_d   = state_q;
		raise     = 1'b0;
		raise_cmd = CMD_RD;
		case (state_q)
			IDLE: begin
				if (!refresh_busy) begin   // nothing goes out inside T_RFC
					if (refresh_due)
						state_d = (open_cnt != '0) ? DO_PREA : DO_REF;
					else if (head_valid) begin
						if (!bank_open)
							state_d = DO_ACT;  // bank closed
						else if (open_row == head_row)
							state_d = DO_COL;  // row hit
						else
							state_d = DO_PRE;  // row miss
					end
				end
			end
			DO_PREA: begin
				raise     = !cmd_valid;
				raise_cmd = CMD_PREA;
				if (issue_fire)
					state_d = DO_REF;
			end
			DO_REF: begin
				raise     = !cmd_valid && act_ok; // T_RP after PREA, same count on all banks
				raise_cmd = CMD_REF;
				if (issue_fire)
					state_d = IDLE;
			end
			DO_PRE: begin
				raise     = !cmd_valid && pre_ok;
				raise_cmd = CMD_PRE;
				if (issue_fire)
					state_d = DO_ACT;
			end
			DO_ACT: begin
				raise     = !cmd_valid && act_ok;
				raise_cmd = CMD_ACT;
				if (issue_fire)
					state_d = DO_COL;
			end
			DO_COL: begin
				raise     = !cmd_valid && col_ok;
				raise_cmd = (head_op == REQ_WR) ? CMD_WR : CMD_RD;
				if (issue_fire)
					state_d = IDLE;
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= IDLE;
			cmd_valid <= 1'b0;
			open_cnt  <= '0;
		end else begin
			state_q <= state_d;
			if (raise)
				cmd_valid <= 1'b1;
			else if (issue_fire)
				cmd_valid <= 1'b0; // held until accepted
			if (issue_fire) begin
				case (cmd)
					CMD_ACT:          open_cnt <= open_cnt + 1'b1;
					CMD_PRE:          open_cnt <= open_cnt - 1'b1;
					CMD_PREA, CMD_REF: open_cnt <= '0;
					default: ;
				endcase
			end
		end
	end

	// command payload, frozen while cmd_valid is high
	always_ff @(posedge clk) begin
		if (raise) begin
			cmd      <= raise_cmd;
			cmd_bg   <= (raise_cmd == CMD_PREA || raise_cmd == CMD_REF) ? '0 : head_bg;
			cmd_bank <= (raise_cmd == CMD_PREA || raise_cmd == CMD_REF) ? '0 : head_bank;
			cmd_row  <= head_row;
			cmd_col  <= head_col;
		end
	end

endmodule : cmd_scheduler

/* verilog/refresh_timer.sv */
`timescale 1ns/1ps

module refresh_timer
	import dram_geometry_pkg::*;
#(
	parameter tcount_t T_REFI = 8'd200,
	parameter tcount_t T_RFC  = 8'd12
) (
	input  logic clk,
	input  logic rst_n,
	input  logic refresh_ack,  // REF went out
	output logic refresh_due,
	output logic refresh_busy  // device blocked for T_RFC
);

	tcount_t refi_cnt; // cycles left until next refresh request
	tcount_t rfc_cnt;  // cycles left in the blocking window

	assign refresh_busy = (rfc_cnt != '0);

	// interval counter, restarts on each ack
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			refi_cnt    <= T_REFI;
			refresh_due <= 1'b0;
		end else if (refresh_ack) begin
			refi_cnt    <= T_REFI;
			refresh_due <= 1'b0;
		end else if (!refresh_due) begin
			if (refi_cnt <= tcount_t'(1)) begin
				refi_cnt    <= '0;
				refresh_due <= 1'b1; // held until the scheduler answers
			end else begin
				refi_cnt <= refi_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rfc_cnt <= '0;
		else if (refresh_ack)
			rfc_cnt <= T_RFC;
		else if (rfc_cnt != '0)
			rfc_cnt <= rfc_cnt - 1'b1;
	end

endmodule : refresh_timer

/* verilog/bank_state.sv */
`timescale 1ns/1ps

module bank_state
	import dram_geometry_pkg::*, dram_cmd_pkg::*;
#(
	parameter tcount_t T_RP  = 8'd3,
	parameter tcount_t T_RCD = 8'd3,
	parameter tcount_t T_CCD = 8'd2
) (
	input  logic      clk,
	input  logic      rst_n,
	input  bank_idx_t look_bank,  // bank of the head request
	input  logic      issue_fire, // a command transferred this cycle
	input  dram_cmd_t issue_cmd,
	input  bank_idx_t issue_bank,
	input  row_t      issue_row,
	output logic      bank_open,
	output row_t      open_row,
	output logic      pre_ok,
	output logic      act_ok,
	output logic      col_ok
);

	logic [NUM_BANKS-1:0] open_q;              // one open flag per bank
	row_t                 row_mem [NUM_BANKS]; // row held open, valid only with open_q
	tcount_t              gap_q   [NUM_BANKS]; // T_RP after PRE, T_RCD after ACT
	tcount_t              ccd_q;               // shared column to column gap

	// status of the looked-up bank
	assign bank_open = open_q[look_bank];
	assign open_row  = row_mem[look_bank];
	assign pre_ok    = open_q[look_bank] && (gap_q[look_bank] == '0);
	assign act_ok    = !open_q[look_bank] && (gap_q[look_bank] == '0);
	assign col_ok    = open_q[look_bank] && (gap_q[look_bank] == '0) && (ccd_q == '0);

	always_ff @(posedge clk) begin
		if (issue_fire && issue_cmd == CMD_ACT)
			row_mem[issue_bank] <= issue_row;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			open_q <= '0; // all banks closed
			for (int i = 0; i < NUM_BANKS; i++)
				gap_q[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				if (gap_q[i] != '0)
					gap_q[i] <= gap_q[i] - 1'b1; // free running down to zero
			end
			if (issue_fire) begin
				case (issue_cmd)
					CMD_PRE: begin
						open_q[issue_bank] <= 1'b0;
						gap_q[issue_bank]  <= T_RP;
					end
					CMD_ACT: begin
						open_q[issue_bank] <= 1'b1;
						gap_q[issue_bank]  <= T_RCD;
					end
					CMD_PREA: begin
						open_q <= '0;
						for (int i = 0; i < NUM_BANKS; i++)
							gap_q[i] <= T_RP; // every bank precharging
					end
					CMD_REF: open_q <= '0; // rows are lost across refresh
					default: ;             // RD and WR leave bank state alone
				endcase
			end
		end
	end

	// T_CCD counter, reloaded by every RD or WR
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ccd_q <= '0;
		else if (issue_fire && (issue_cmd == CMD_RD || issue_cmd == CMD_WR))
			ccd_q <= T_CCD;
		else if (ccd_q != '0)
			ccd_q <= ccd_q - 1'b1;
	end

endmodule : bank_state

/* verilog/request_fifo.sv */
`timescale 1ns/1ps

module request_fifo
	import dram_geometry_pkg::*, dram_cmd_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    req_valid,
	input  req_op_t req_op,
	input  addr_t   req_addr,
	output logic    req_ready,
	output logic    head_valid,
	output req_op_t head_op,
	output addr_t   head_addr,
	input  logic    head_pop    // column command of the head just went out
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	req_op_t op_mem   [FIFO_DEPTH]; // storage, no reset
	addr_t   addr_mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;  // entries held
	logic             push;
	logic             pop;

	assign req_ready  = (count != CNT_W'(FIFO_DEPTH)); // room left, independent of req_valid
	assign head_valid = (count != '0);
	assign head_op    = op_mem[rd_ptr];
	assign head_addr  = addr_mem[rd_ptr];

	assign push = req_valid && req_ready;
	assign pop  = head_pop && head_valid;

	always_ff @(posedge clk) begin
		if (push) begin
			op_mem[wr_ptr]   <= req_op;
			addr_mem[wr_ptr] <= req_addr;
		end
	end

	// pointers wrap at FIFO_DEPTH, so any depth works
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1; // freed slot shows on req_ready next cycle
				default: count <= count;        // none, or push and pop together
			endcase
		end
	end

endmodule : request_fifo

/* verilog/dram_cmd_pkg.sv */
package dram_cmd_pkg;

	// opcode carried with each request
	typedef enum logic {
		REQ_RD = 1'b0,
		REQ_WR = 1'b1
	} req_op_t;

	// commands put on the outgoing stream
	typedef enum logic [2:0] {
		CMD_PRE  = 3'd0, // close one bank
		CMD_ACT  = 3'd1, // open a row
		CMD_RD   = 3'd2,
		CMD_WR   = 3'd3,
		CMD_PREA = 3'd4, // close every bank
		CMD_REF  = 3'd5
	} dram_cmd_t;

	// scheduler FSM
	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		DO_PREA = 3'd1,
		DO_REF  = 3'd2,
		DO_PRE  = 3'd3,
		DO_ACT  = 3'd4,
		DO_COL  = 3'd5
	} sched_state_t;

endpackage : dram_cmd_pkg

/* verilog/dram_geometry_pkg.sv */
package dram_geometry_pkg;

	// request address layout, low to high: column, bank, bank group, row
	localparam int ADDR_WIDTH = 19;
	localparam int COL_WIDTH  = 7;
	localparam int BANK_WIDTH = 2;
	localparam int BG_WIDTH   = 2;
	localparam int ROW_WIDTH  = 8;

	// field positions inside the address
	localparam int COL_LSB  = 0;
	localparam int BANK_LSB = COL_LSB + COL_WIDTH;
	localparam int BG_LSB   = BANK_LSB + BANK_WIDTH;
	localparam int ROW_LSB  = BG_LSB + BG_WIDTH;

	localparam int NUM_BANKS = (2 ** BG_WIDTH) * (2 ** BANK_WIDTH); // 16 banks total

	// counter width for every timing gap and timing parameter
	localparam int TCOUNT_WIDTH = 8;

	typedef logic [ADDR_WIDTH-1:0] addr_t; // whole request address

	typedef logic [COL_WIDTH-1:0]  col_t;
	typedef logic [BANK_WIDTH-1:0] bank_t;
	typedef logic [BG_WIDTH-1:0]   bg_t;
	typedef logic [ROW_WIDTH-1:0]  row_t;

	// flat bank number, bank group in the upper bits
	typedef logic [BG_WIDTH+BANK_WIDTH-1:0] bank_idx_t;

	typedef logic [TCOUNT_WIDTH-1:0] tcount_t;

endpackage : dram_geometry_pkg
